// File: all.f
+incdir+logic
+incdir+bench
logic/cpu_ctrl_pkg.sv
logic/reg_list_scanner.sv
logic/multi_transfer_sequencer.sv
logic/control_decoder.sv
logic/cpu_controller.sv
bench/cpu_controller_tb.sv

// File: bench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: instruction word, alu_op_o, alu_src_a_o, alu_src_b_o, then the flags
// {update_flag, reg_write_en, mem_read_en, mem_write_en, reg_data_src, reg_3_select}
task automatic load_vector_table();
    // shift, add/subtract, move and compare immediates
    add_row(16'h0088, ALU_LSL, SRC_REG,  SRC_IMM, 6'b110000);
    add_row(16'h0888, ALU_LSR, SRC_REG,  SRC_IMM, 6'b110000);
    add_row(16'h1088, ALU_ASR, SRC_REG,  SRC_IMM, 6'b110000);
    add_row(16'h1888, ALU_ADD, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h1A88, ALU_SUB, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h1C88, ALU_ADD, SRC_REG,  SRC_IMM, 6'b110000);
    add_row(16'h1E88, ALU_SUB, SRC_REG,  SRC_IMM, 6'b110000);
    add_row(16'h2012, ALU_ADD, SRC_ZERO, SRC_IMM, 6'b110000);
    add_row(16'h2812, ALU_SUB, SRC_REG,  SRC_IMM, 6'b100000);
    add_row(16'h3012, ALU_ADD, SRC_REG,  SRC_IMM, 6'b110000);
    add_row(16'h3812, ALU_SUB, SRC_REG,  SRC_IMM, 6'b110000);
    // the sixteen data-processing codes in order, TST CMP and CMN write no register
    add_row(16'h400A, ALU_AND, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h404A, ALU_XOR, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h408A, ALU_LSL, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h40CA, ALU_LSR, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h410A, ALU_ASR, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h414A, ALU_ADC, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h418A, ALU_SBC, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h41CA, ALU_ROR, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h420A, ALU_AND, SRC_REG,  SRC_REG, 6'b100000);
    add_row(16'h424A, ALU_SUB, SRC_ZERO, SRC_REG, 6'b110000);
    add_row(16'h428A, ALU_SUB, SRC_REG,  SRC_REG, 6'b100000);
    add_row(16'h42CA, ALU_ADD, SRC_REG,  SRC_REG, 6'b100000);
    add_row(16'h430A, ALU_OR,  SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h434A, ALU_MUL, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h438A, ALU_BIC, SRC_REG,  SRC_REG, 6'b110000);
    add_row(16'h43CA, ALU_NOT, SRC_REG,  SRC_REG, 6'b110000);
    // register-offset forms: STR, STRB, LDRSB, LDR, LDRSH
    add_row(16'h5088, ALU_ADD, SRC_REG,  SRC_REG, 6'b000101);
    add_row(16'h5488, ALU_ADD, SRC_REG,  SRC_REG, 6'b000101);
    add_row(16'h5688, ALU_ADD, SRC_REG,  SRC_REG, 6'b011010);
    add_row(16'h5888, ALU_ADD, SRC_REG,  SRC_REG, 6'b011010);
    add_row(16'h5E88, ALU_ADD, SRC_REG,  SRC_REG, 6'b011010);
    // immediate-offset word, byte and halfword forms
    add_row(16'h6088, ALU_ADD, SRC_REG,  SRC_IMM, 6'b000100);
    add_row(16'h6888, ALU_ADD, SRC_REG,  SRC_IMM, 6'b011010);
    add_row(16'h7088, ALU_ADD, SRC_REG,  SRC_IMM, 6'b000100);
    add_row(16'h8088, ALU_ADD, SRC_REG,  SRC_IMM, 6'b000100);
    add_row(16'h8888, ALU_ADD, SRC_REG,  SRC_IMM, 6'b011010);
    // unsupported groups keep every control inactive
    add_row(16'hB000, ALU_ADD, SRC_REG,  SRC_REG, 6'b000000);
    add_row(16'h9000, ALU_ADD, SRC_REG,  SRC_REG, 6'b000000);
    add_row(16'hD0FE, ALU_ADD, SRC_REG,  SRC_REG, 6'b000000);
endtask

`endif

// File: bench/cpu_controller_tb.sv
`timescale 1ns/100ps

`include "cpu_ctrl_macros.svh"

module cpu_controller_tb
    import cpu_ctrl_pkg::*;
();

    localparam int HALF_PERIOD = 4;
    localparam int SEQ_TIMEOUT = 12;

    logic                       clk;
    logic                       reset;
    logic                       is_valid;
    logic [`CPU_INSTR_W-1:0]    instruction;
    logic                       update_flag;
    logic                       mem_write_en;
    logic                       mem_read_en;
    logic                       reg_write_en;
    reg_data_src_t              reg_data_src;
    alu_src_t                   alu_src_a;
    alu_src_t                   alu_src_b;
    alu_op_t                    alu_op;
    logic                       stall;
    addr_src_t                  reg_addr_2_src;
    addr_src_t                  reg_dest_src;
    logic                       reg_3_select;
    logic [`CPU_WORD-1:0]       offset_imm;
    logic [`CPU_REG_ADDR_W-1:0] ctrl_reg_addr;

    logic [`CPU_INSTR_W-1:0] vec_instr[$];
    alu_op_t                 vec_op[$];
    alu_src_t                vec_src_a[$];
    alu_src_t                vec_src_b[$];
    logic [5:0]              vec_flags[$];

    logic [31:0] rng_state;
    logic [7:0]  list;
    logic [2:0]  base;

    cpu_controller u_dut (
        .clk_i            (clk),
        .reset_i          (reset),
        .is_valid_i       (is_valid),
        .instruction_i    (instruction),
        .update_flag_o    (update_flag),
        .mem_write_en_o   (mem_write_en),
        .mem_read_en_o    (mem_read_en),
        .reg_write_en_o   (reg_write_en),
        .reg_data_src_o   (reg_data_src),
        .alu_src_a_o      (alu_src_a),
        .alu_src_b_o      (alu_src_b),
        .alu_op_o         (alu_op),
        .stall_o          (stall),
        .reg_addr_2_src_o (reg_addr_2_src),
        .reg_dest_src_o   (reg_dest_src),
        .reg_3_select_o   (reg_3_select),
        .offset_imm_o     (offset_imm),
        .ctrl_reg_addr_o  (ctrl_reg_addr)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic add_row(input logic [15:0] instr, input alu_op_t op, input alu_src_t src_a,
                           input alu_src_t src_b, input logic [5:0] flags);
        vec_instr.push_back(instr);
        vec_op.push_back(op);
        vec_src_a.push_back(src_a);
        vec_src_b.push_back(src_b);
        vec_flags.push_back(flags);
    endtask

    `include "tb_vectors.svh"

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h for instruction 0x%04h",
                     name, expected, actual, instruction);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_table_row(input int i);
        check_field("alu_op_o", 32'(vec_op[i]), 32'(alu_op));
        check_field("alu_src_a_o", 32'(vec_src_a[i]), 32'(alu_src_a));
        check_field("alu_src_b_o", 32'(vec_src_b[i]), 32'(alu_src_b));
        check_field("update_flag_o", 32'(vec_flags[i][5]), 32'(update_flag));
        check_field("reg_write_en_o", 32'(vec_flags[i][4]), 32'(reg_write_en));
        check_field("mem_read_en_o", 32'(vec_flags[i][3]), 32'(mem_read_en));
        check_field("mem_write_en_o", 32'(vec_flags[i][2]), 32'(mem_write_en));
        check_field("reg_data_src_o", 32'(vec_flags[i][1]), 32'(reg_data_src));
        check_field("reg_3_select_o", 32'(vec_flags[i][0]), 32'(reg_3_select));
        check_field("stall_o", 32'(0), 32'(stall));
    endtask

    // STM walks the list upward and LDM downward, then one unstalled writeback beat
    task automatic run_multi(input logic is_ldm, input logic [7:0] regs, input logic [2:0] rb);
        logic [3:0] order[$];
        int         n;
        int         k;
        logic       base_write;
        for (int i = 0; i < 8; i++) begin
            if (is_ldm && regs[7-i]) begin
                order.push_back(4'(7 - i));
            end else if (!is_ldm && regs[i]) begin
                order.push_back(4'(i));
            end
        end
        n = order.size();
        base_write = !(is_ldm && regs[rb]);
        instruction = {4'b1100, is_ldm, rb, regs};
        is_valid = 1'b1;
        k = 0;
        #(HALF_PERIOD - 1);
        while (stall === 1'b1 && k < SEQ_TIMEOUT) begin
            check_field("ctrl_reg_addr_o", 32'(order[k]), 32'(ctrl_reg_addr));
            check_field("alu_src_b_o", 32'(SRC_BEAT_OFFSET), 32'(alu_src_b));
            if (is_ldm) begin
                check_field("offset_imm_o", 32'(4 * (n - 1 - k)), offset_imm);
                check_field("reg_write_en_o", 32'(1), 32'(reg_write_en));
                check_field("reg_data_src_o", 32'(DATA_FROM_MEM), 32'(reg_data_src));
                check_field("reg_dest_src_o", 32'(ADDR_FROM_CONTROLLER), 32'(reg_dest_src));
                check_field("mem_write_en_o", 32'(0), 32'(mem_write_en));
            end else begin
                check_field("offset_imm_o", 32'(4 * k), offset_imm);
                check_field("mem_write_en_o", 32'(1), 32'(mem_write_en));
                check_field("reg_write_en_o", 32'(0), 32'(reg_write_en));
                check_field("reg_addr_2_src_o", 32'(ADDR_FROM_CONTROLLER),
                            32'(reg_addr_2_src));
            end
            k++;
            @(negedge clk);
            #(HALF_PERIOD - 1);
        end
        assert (k < SEQ_TIMEOUT) else begin
            $display("multi-register sequence did not reach its writeback beat in time");
            abort_run();
        end
        assert (k == n) else begin
            $display("sequence stalled for %0d cycles but the list holds %0d registers", k, n);
            abort_run();
        end
        // writeback beat moves the base register past the block
        check_field("ctrl_reg_addr_o", 32'(rb), 32'(ctrl_reg_addr));
        check_field("offset_imm_o", 32'(4 * n), offset_imm);
        check_field("reg_write_en_o", 32'(base_write), 32'(reg_write_en));
        check_field("reg_data_src_o", 32'(DATA_FROM_ALU), 32'(reg_data_src));
        check_field("reg_dest_src_o", 32'(ADDR_FROM_CONTROLLER), 32'(reg_dest_src));
        check_field("mem_write_en_o", 32'(0), 32'(mem_write_en));
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        is_valid = 1'b0;
        instruction = 16'hB000;
        rng_state = 32'd40;
        load_vector_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // an unsupported instruction right after reset leaves everything idle
        is_valid = 1'b1;
        #(HALF_PERIOD - 1);
        check_field("stall_o", 32'(0), 32'(stall));
        check_field("mem_write_en_o", 32'(0), 32'(mem_write_en));
        check_field("mem_read_en_o", 32'(0), 32'(mem_read_en));
        check_field("reg_write_en_o", 32'(0), 32'(reg_write_en));
        @(negedge clk);

        for (int i = 0; i < vec_instr.size(); i++) begin
            instruction = vec_instr[i];
            #(HALF_PERIOD - 1);
            check_table_row(i);
            @(negedge clk);
        end

        for (int i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            list = (rng_state[7:0] == 8'h00) ? 8'h81 : rng_state[7:0];
            base = rng_state[10:8];
            run_multi(1'b0, list, base);
        end

        // alternate LDM runs with and without the base in the list
        for (int i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            base = rng_state[10:8];
            list = rng_state[7:0];
            if (i[0]) begin
                list[base] = 1'b1;
            end else begin
                list[base] = 1'b0;
            end
            if (list == 8'h00) begin
                list = 8'h01 << 3'(base + 3'd1);
            end
            run_multi(1'b1, list, base);
        end

        // a one-cycle drop of is_valid in the middle of an STM restarts the walk
        rng_state = xorshift32(rng_state);
        list = rng_state[7:0] | 8'h0B;
        base = rng_state[10:8];
        instruction = {5'b11000, base, list};
        #(HALF_PERIOD - 1);
        check_field("ctrl_reg_addr_o", 32'(0), 32'(ctrl_reg_addr));
        @(negedge clk);
        #(HALF_PERIOD - 1);
        check_field("ctrl_reg_addr_o", 32'(1), 32'(ctrl_reg_addr));
        @(negedge clk);
        is_valid = 1'b0;
        @(negedge clk);
        run_multi(1'b0, list, base);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: logic/control_decoder.sv
`timescale 1ns/100ps

`include "cpu_ctrl_macros.svh"

module control_decoder
    import cpu_ctrl_pkg::*;
(
    input  logic [`CPU_INSTR_W-1:0]    instruction_i,
    input  logic                       seq_stall_i,
    input  logic                       seq_mem_write_i,
    input  logic                       seq_reg_write_i,
    input  reg_data_src_t              seq_data_src_i,
    input  addr_src_t                  seq_addr_2_src_i,
    input  addr_src_t                  seq_dest_src_i,
    input  logic [`CPU_REG_ADDR_W-1:0] seq_reg_addr_i,
    input  logic [`CPU_WORD-1:0]       seq_offset_i,
    output logic                       multi_active_o,
    output logic                       is_load_o,
    output logic                       update_flag_o,
    output logic                       mem_write_en_o,
    output logic                       mem_read_en_o,
    output logic                       reg_write_en_o,
    output reg_data_src_t              reg_data_src_o,
    output alu_src_t                   alu_src_a_o,
    output alu_src_t                   alu_src_b_o,
    output alu_op_t                    alu_op_o,
    output logic                       stall_o,
    output addr_src_t                  reg_addr_2_src_o,
    output addr_src_t                  reg_dest_src_o,
    output logic                       reg_3_select_o,
    output logic [`CPU_WORD-1:0]       offset_imm_o,
    output logic [`CPU_REG_ADDR_W-1:0] ctrl_reg_addr_o
);

    instr_class_t instr_class;
    logic         is_load_form;

    always_comb begin
        casez (instruction_i[15:10])
            6'b00????: instr_class = CLASS_SHIFT_ADD_IMM;
            6'b010000: instr_class = CLASS_DATA_PROC;
            6'b0101??: instr_class = CLASS_LS_REG;
            6'b011???: instr_class = CLASS_LS_IMM;
            6'b1000??: instr_class = CLASS_LS_IMM;
            6'b11000?: instr_class = CLASS_STM;
            6'b11001?: instr_class = CLASS_LDM;
            default:   instr_class = CLASS_OTHER;
        endcase
    end

    assign multi_active_o = (instr_class == CLASS_STM) || (instr_class == CLASS_LDM);
    assign is_load_o      = (instr_class == CLASS_LDM);

    // LDRSB sits in the store half of the register-offset opcodes
    assign is_load_form = instruction_i[11] ||
                          ((instr_class == CLASS_LS_REG) && (instruction_i[10:9] == 2'b11));

    always_comb begin
        update_flag_o    = 1'b0;
        mem_write_en_o   = 1'b0;
        mem_read_en_o    = 1'b0;
        reg_write_en_o   = 1'b0;
        reg_data_src_o   = DATA_FROM_ALU;
        alu_src_a_o      = SRC_REG;
        alu_src_b_o      = SRC_REG;
        alu_op_o         = ALU_ADD;
        stall_o          = 1'b0;
        reg_addr_2_src_o = ADDR_FROM_INSTRUCTION;
        reg_dest_src_o   = ADDR_FROM_INSTRUCTION;
        reg_3_select_o   = 1'b0;
        offset_imm_o     = '0;
        ctrl_reg_addr_o  = '0;

        case (instr_class)
            CLASS_SHIFT_ADD_IMM: begin
                update_flag_o  = 1'b1;
                reg_write_en_o = 1'b1;
                alu_src_b_o    = SRC_IMM;
                case (instruction_i[13:11])
                    3'b000: alu_op_o = ALU_LSL;
                    3'b001: alu_op_o = ALU_LSR;
                    3'b010: alu_op_o = ALU_ASR;
                    3'b011: begin
                        // bit 10 picks imm3 over Rm, bit 9 picks subtract
                        alu_op_o    = instruction_i[9] ? ALU_SUB : ALU_ADD;
                        alu_src_b_o = instruction_i[10] ? SRC_IMM : SRC_REG;
                    end
                    3'b100: alu_src_a_o = SRC_ZERO;
                    3'b101: begin
                        alu_op_o       = ALU_SUB;
                        reg_write_en_o = 1'b0;
                    end
                    3'b110: alu_op_o = ALU_ADD;
                    default: alu_op_o = ALU_SUB;
                endcase
            end
            CLASS_DATA_PROC: begin
                update_flag_o  = 1'b1;
                reg_write_en_o = 1'b1;
                case (instruction_i[9:6])
                    4'h0: alu_op_o = ALU_AND;
                    4'h1: alu_op_o = ALU_XOR;
                    4'h2: alu_op_o = ALU_LSL;
                    4'h3: alu_op_o = ALU_LSR;
                    4'h4: alu_op_o = ALU_ASR;
                    4'h5: alu_op_o = ALU_ADC;
                    4'h6: alu_op_o = ALU_SBC;
                    4'h7: alu_op_o = ALU_ROR;
                    4'h8: begin
                        alu_op_o       = ALU_AND;
                        reg_write_en_o = 1'b0;
                    end
                    4'h9: begin
                        alu_op_o    = ALU_SUB;
                        alu_src_a_o = SRC_ZERO;
                    end
                    4'hA: begin
                        alu_op_o       = ALU_SUB;
                        reg_write_en_o = 1'b0;
                    end
                    4'hB: reg_write_en_o = 1'b0;
                    4'hC: alu_op_o = ALU_OR;
                    4'hD: alu_op_o = ALU_MUL;
                    4'hE: alu_op_o = ALU_BIC;
                    default: alu_op_o = ALU_NOT;
                endcase
            end
            CLASS_LS_REG, CLASS_LS_IMM: begin
                if (instr_class == CLASS_LS_IMM) begin
                    alu_src_b_o = SRC_IMM;
                end
                if (is_load_form) begin
                    mem_read_en_o  = 1'b1;
                    reg_write_en_o = 1'b1;
                    reg_data_src_o = DATA_FROM_MEM;
                end else begin
                    mem_write_en_o = 1'b1;
                    // register-offset stores need Rd on the third read port
                    reg_3_select_o = (instr_class == CLASS_LS_REG);
                end
            end
            CLASS_STM, CLASS_LDM: begin
                // the sequencer drives every transfer control and operand b adds the beat offset
                alu_src_b_o      = SRC_BEAT_OFFSET;
                stall_o          = seq_stall_i;
                mem_write_en_o   = seq_mem_write_i;
                reg_write_en_o   = seq_reg_write_i;
                reg_data_src_o   = seq_data_src_i;
                reg_addr_2_src_o = seq_addr_2_src_i;
                reg_dest_src_o   = seq_dest_src_i;
                ctrl_reg_addr_o  = seq_reg_addr_i;
                offset_imm_o     = seq_offset_i;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/cpu_controller.sv
`timescale 1ns/100ps

`include "cpu_ctrl_macros.svh"

module cpu_controller
    import cpu_ctrl_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       is_valid_i,
    input  logic [`CPU_INSTR_W-1:0]    instruction_i,
    output logic                       update_flag_o,
    output logic                       mem_write_en_o,
    output logic                       mem_read_en_o,
    output logic                       reg_write_en_o,
    output reg_data_src_t              reg_data_src_o,
    output alu_src_t                   alu_src_a_o,
    output alu_src_t                   alu_src_b_o,
    output alu_op_t                    alu_op_o,
    output logic                       stall_o,
    output addr_src_t                  reg_addr_2_src_o,
    output addr_src_t                  reg_dest_src_o,
    output logic                       reg_3_select_o,
    output logic [`CPU_WORD-1:0]       offset_imm_o,
    output logic [`CPU_REG_ADDR_W-1:0] ctrl_reg_addr_o
);

    logic                       multi_active;
    logic                       is_load;
    logic                       seq_stall;
    logic                       seq_mem_write;
    logic                       seq_reg_write;
    reg_data_src_t              seq_data_src;
    addr_src_t                  seq_addr_2_src;
    addr_src_t                  seq_dest_src;
    logic [`CPU_REG_ADDR_W-1:0] seq_reg_addr;
    logic [`CPU_WORD-1:0]       seq_offset;

    control_decoder u_decoder (
        .instruction_i    (instruction_i),
        .seq_stall_i      (seq_stall),
        .seq_mem_write_i  (seq_mem_write),
        .seq_reg_write_i  (seq_reg_write),
        .seq_data_src_i   (seq_data_src),
        .seq_addr_2_src_i (seq_addr_2_src),
        .seq_dest_src_i   (seq_dest_src),
        .seq_reg_addr_i   (seq_reg_addr),
        .seq_offset_i     (seq_offset),
        .multi_active_o   (multi_active),
        .is_load_o        (is_load),
        .update_flag_o    (update_flag_o),
        .mem_write_en_o   (mem_write_en_o),
        .mem_read_en_o    (mem_read_en_o),
        .reg_write_en_o   (reg_write_en_o),
        .reg_data_src_o   (reg_data_src_o),
        .alu_src_a_o      (alu_src_a_o),
        .alu_src_b_o      (alu_src_b_o),
        .alu_op_o         (alu_op_o),
        .stall_o          (stall_o),
        .reg_addr_2_src_o (reg_addr_2_src_o),
        .reg_dest_src_o   (reg_dest_src_o),
        .reg_3_select_o   (reg_3_select_o),
        .offset_imm_o     (offset_imm_o),
        .ctrl_reg_addr_o  (ctrl_reg_addr_o)
    );

    // the list sits in bits 7:0 and the low base register in bits 10:8
    multi_transfer_sequencer u_sequencer (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .is_valid_i       (is_valid_i),
        .multi_active_i   (multi_active),
        .is_load_i        (is_load),
        .reg_list_i       (instruction_i[7:0]),
        .base_reg_i       ({1'b0, instruction_i[10:8]}),
        .seq_stall_o      (seq_stall),
        .seq_mem_write_o  (seq_mem_write),
        .seq_reg_write_o  (seq_reg_write),
        .seq_data_src_o   (seq_data_src),
        .seq_addr_2_src_o (seq_addr_2_src),
        .seq_dest_src_o   (seq_dest_src),
        .seq_reg_addr_o   (seq_reg_addr),
        .seq_offset_o     (seq_offset)
    );

endmodule

// File: logic/cpu_ctrl_macros.svh
`ifndef CPU_CTRL_MACROS_SVH
`define CPU_CTRL_MACROS_SVH

// width of a data word and of the offset immediate sent to the ALU
`define CPU_WORD 32

// thumb instructions are a single halfword
`define CPU_INSTR_W 16

// register numbers cover r0 to r15
`define CPU_REG_ADDR_W 4

// the multiple-transfer list only reaches the low registers r0 to r7
`define CPU_REG_LIST_W 8

// beat counter, wide enough for a full list plus the writeback beat
`define CPU_BEAT_W 4

// address step between consecutive transferred registers
`define CPU_BYTES_PER_REG 4

`endif

// File: logic/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // operations understood by the execute stage ALU
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_ADC = 4'd2,
        ALU_SBC = 4'd3,
        ALU_AND = 4'd4,
        ALU_OR  = 4'd5,
        ALU_XOR = 4'd6,
        ALU_BIC = 4'd7,
        ALU_NOT = 4'd8,
        ALU_LSL = 4'd9,
        ALU_LSR = 4'd10,
        ALU_ASR = 4'd11,
        ALU_ROR = 4'd12,
        ALU_MUL = 4'd13
    } alu_op_t;

    // operand sources for both ALU inputs
    typedef enum logic [1:0] {
        SRC_REG         = 2'd0,
        SRC_IMM         = 2'd1,
        SRC_ZERO        = 2'd2,
        SRC_BEAT_OFFSET = 2'd3
    } alu_src_t;

    // where the register file write data comes from
    typedef enum logic {
        DATA_FROM_ALU = 1'b0,
        DATA_FROM_MEM = 1'b1
    } reg_data_src_t;

    // register number taken from the instruction fields or from the controller
    typedef enum logic {
        ADDR_FROM_INSTRUCTION = 1'b0,
        ADDR_FROM_CONTROLLER  = 1'b1
    } addr_src_t;

    // instruction groups as selected by bits 15:10
    typedef enum logic [2:0] {
        CLASS_SHIFT_ADD_IMM = 3'd0,
        CLASS_DATA_PROC     = 3'd1,
        CLASS_LS_REG        = 3'd2,
        CLASS_LS_IMM        = 3'd3,
        CLASS_STM           = 3'd4,
        CLASS_LDM           = 3'd5,
        CLASS_OTHER         = 3'd6
    } instr_class_t;

endpackage

// File: logic/multi_transfer_sequencer.sv
`timescale 1ns/100ps

`include "cpu_ctrl_macros.svh"

module multi_transfer_sequencer
    import cpu_ctrl_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       is_valid_i,
    input  logic                       multi_active_i,
    input  logic                       is_load_i,
    input  logic [`CPU_REG_LIST_W-1:0] reg_list_i,
    input  logic [`CPU_REG_ADDR_W-1:0] base_reg_i,
    output logic                       seq_stall_o,
    output logic                       seq_mem_write_o,
    output logic                       seq_reg_write_o,
    output reg_data_src_t              seq_data_src_o,
    output addr_src_t                  seq_addr_2_src_o,
    output addr_src_t                  seq_dest_src_o,
    output logic [`CPU_REG_ADDR_W-1:0] seq_reg_addr_o,
    output logic [`CPU_WORD-1:0]       seq_offset_o
);

    logic [`CPU_REG_ADDR_W-1:0] pick_addr;
    logic                       remaining_nonzero;
    logic [`CPU_BEAT_W-1:0]     beat;
    logic                       base_in_list;
    logic [`CPU_BEAT_W-1:0]     list_count;
    logic [`CPU_WORD-1:0]       beat_bytes;
    logic [`CPU_WORD-1:0]       list_bytes;

    reg_list_scanner u_scanner (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .clear_i             (~seq_stall_o | ~is_valid_i),
        .advance_i           (seq_stall_o),
        .descending_i        (is_load_i),
        .reg_list_i          (reg_list_i),
        .base_reg_i          (base_reg_i),
        .pick_addr_o         (pick_addr),
        .remaining_nonzero_o (remaining_nonzero),
        .beat_o              (beat),
        .base_in_list_o      (base_in_list)
    );

    // population count of the register list
    always_comb begin
        list_count = '0;
        for (int i = 0; i < `CPU_REG_LIST_W; i++) begin
            list_count = list_count + `CPU_BEAT_W'(reg_list_i[i]);
        end
    end

    assign beat_bytes = `CPU_WORD'(beat) * `CPU_WORD'(`CPU_BYTES_PER_REG);
    assign list_bytes = `CPU_WORD'(list_count) * `CPU_WORD'(`CPU_BYTES_PER_REG);

    assign seq_stall_o = multi_active_i & remaining_nonzero;

    always_comb begin
        seq_mem_write_o  = 1'b0;
        seq_reg_write_o  = 1'b0;
        seq_data_src_o   = DATA_FROM_ALU;
        seq_addr_2_src_o = ADDR_FROM_INSTRUCTION;
        seq_dest_src_o   = ADDR_FROM_CONTROLLER;
        seq_reg_addr_o   = pick_addr;
        seq_offset_o     = beat_bytes;

        if (seq_stall_o && !is_load_i) begin
            // STM reads the picked register on port 2 and stores it upward
            seq_dest_src_o   = ADDR_FROM_INSTRUCTION;
            seq_addr_2_src_o = ADDR_FROM_CONTROLLER;
            seq_mem_write_o  = 1'b1;
        end else if (seq_stall_o) begin
            // LDM fills from the top of the block down towards the base address
            seq_reg_write_o = 1'b1;
            seq_data_src_o  = DATA_FROM_MEM;
            seq_offset_o    = list_bytes - `CPU_WORD'(`CPU_BYTES_PER_REG) - beat_bytes;
        end else begin
            // writeback beat moves the base past the whole block
            seq_reg_addr_o  = base_reg_i;
            seq_offset_o    = list_bytes;
            seq_reg_write_o = multi_active_i & ~(is_load_i & base_in_list);
        end
    end

endmodule

// File: logic/reg_list_scanner.sv
`timescale 1ns/100ps

`include "cpu_ctrl_macros.svh"

module reg_list_scanner (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       clear_i,
    input  logic                       advance_i,
    input  logic                       descending_i,
    input  logic [`CPU_REG_LIST_W-1:0] reg_list_i,
    input  logic [`CPU_REG_ADDR_W-1:0] base_reg_i,
    output logic [`CPU_REG_ADDR_W-1:0] pick_addr_o,
    output logic                       remaining_nonzero_o,
    output logic [`CPU_BEAT_W-1:0]     beat_o,
    output logic                       base_in_list_o
);

    // bits still set here belong to registers not yet transferred
    logic [`CPU_REG_LIST_W-1:0] remaining_mask;
    logic [`CPU_REG_LIST_W-1:0] active;

    assign active = reg_list_i & remaining_mask;
    assign remaining_nonzero_o = |active;

    // the last match in the loop wins, so the scan direction picks the
    // lowest register for an ascending walk and the highest otherwise
    always_comb begin
        pick_addr_o = '0;
        for (int i = 0; i < `CPU_REG_LIST_W; i++) begin
            if (descending_i) begin
                if (active[i]) begin
                    pick_addr_o = `CPU_REG_ADDR_W'(i);
                end
            end else if (active[`CPU_REG_LIST_W-1-i]) begin
                pick_addr_o = `CPU_REG_ADDR_W'(`CPU_REG_LIST_W-1-i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            remaining_mask <= '1;
            beat_o         <= '0;
            base_in_list_o <= 1'b0;
        end else if (advance_i) begin
            remaining_mask <= remaining_mask & ~(`CPU_REG_LIST_W'(1) << pick_addr_o);
            beat_o         <= beat_o + 1'b1;
            // once the base has been loaded its writeback must be suppressed
            if (pick_addr_o == base_reg_i) begin
                base_in_list_o <= 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the controller testbench with Verilator and runs it into a log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f all.f --top-module cpu_controller_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vcpu_controller_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^>>> PASS$" "$LOG_FILE"; then
    echo "result: passed"
    exit 0
else
    echo "result: failed"
    exit 1
fi
